/* vlog.f */
+incdir+include
logic/lsu_pkg.sv
logic/mem_bus_if.sv
logic/lsu_ctrl.sv
logic/store_align.sv
logic/load_extend.sv
logic/lsu_sram.sv
logic/lsu_top.sv
bench/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator; pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb -f vlog.f -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* bench/lsu_tb.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_tb;
	import lsu_pkg::*;

	logic        clock;
	logic        reset;
	logic        ren;
	logic        wen;
	logic [2:0]  funct3;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm;
	logic [31:0] load_data;
	logic        done;
	logic        fault;
	logic        busy;

	logic [7:0]  shadow [4*`LSU_MEM_WORDS];    // byte image of what the memory should hold
	logic [15:0] lfsr;
	logic [31:0] model_data;                   // expected value of load_data
	int          edge_count = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	logic [31:0] exp_data_q[$];
	logic        exp_fault_q[$];
	int          exp_lat_q[$];
	int          start_q[$];
	string       tag_q[$];

	lsu_top dut_i (
		.clock(clock), .reset(reset), .ren(ren), .wen(wen), .funct3(funct3),
		.src1(src1), .src2(src2), .imm(imm), .load_data(load_data),
		.done(done), .fault(fault), .busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) edge_count <= edge_count + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random source and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];    // x^16 + x^14 + x^13 + x^11 + 1
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// illegal codes and accesses not on a multiple of their size never reach the bus
	function automatic logic bad_access(input logic store, input logic [2:0] op,
			input logic [31:0] addr);
		int size;
		size = 1 << op[1:0];
		if (store && op > 3'd2)
			return 1'b1;
		if (!store && (op == 3'd3 || op > 3'd5))
			return 1'b1;
		return (addr % size) != 0;
	endfunction

	function automatic logic [31:0] ref_result(input logic store, input logic [2:0] op,
			input logic [31:0] addr, input logic [31:0] prev, output logic flt);
		int a;
		flt = bad_access(store, op, addr) || addr >= 4 * `LSU_MEM_WORDS;
		if (flt || store)
			return prev;
		a = int'(addr);
		case (op)
			OP_LB:   return {{24{shadow[a][7]}}, shadow[a]};
			OP_LBU:  return {24'h0, shadow[a]};
			OP_LH:   return {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
			OP_LHU:  return {16'h0, shadow[a+1], shadow[a]};
			default: return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks and the checking process
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_fault(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("FAILED at %0t: %s done after %0d edges, expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	always @(negedge clock) begin : compare
		string tag;
		if (!reset && done) begin
			if (tag_q.size() == 0) begin
				$display("done pulsed at %0t while no access was outstanding", $time);
				other_errors++;
			end else begin
				tag = tag_q.pop_front();
				check_data(load_data, exp_data_q.pop_front(), {tag, " load_data"});
				check_fault(fault, exp_fault_q.pop_front(), {tag, " fault"});
				check_latency(edge_count - start_q.pop_front(), exp_lat_q.pop_front(), tag);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic start_access(input logic store, input logic [2:0] op, input logic [31:0] base,
			input logic [31:0] offs, input logic [31:0] data);
		logic [31:0] addr;
		logic [31:0] exp;
		logic        flt;
		int          n;
		addr = base + offs;
		n = 0;
		while (busy && n < 20) begin
			@(negedge clock);
			n++;
		end
		if (busy) begin
			$display("unit still busy 20 cycles after the last access at %0t", $time);
			other_errors++;
		end
		exp = ref_result(store, op, addr, model_data, flt);
		if (store && !flt) begin
			for (int i = 0; i < (1 << op[1:0]); i++)
				shadow[int'(addr) + i] = data[8*i +: 8];
		end
		model_data = exp;
		@(posedge clock);
		ren <= !store;
		wen <= store;
		funct3 <= op;
		src1 <= base;
		src2 <= data;
		imm <= offs;
		@(posedge clock);    // the DUT takes the strobe on this edge
		ren <= 1'b0;
		wen <= 1'b0;
		@(negedge clock);
		exp_data_q.push_back(exp);
		exp_fault_q.push_back(flt);
		exp_lat_q.push_back(bad_access(store, op, addr) ? 1 : 3);
		start_q.push_back(edge_count);
		tag_q.push_back($sformatf("%s op %0d addr %h", store ? "store" : "load", op, addr));
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		do begin
			@(negedge clock);
			check_fault(busy, 1'b1, "busy while an access is outstanding");
			n++;
		end while (!done && n < 20);
		if (!done) begin
			$display("no done within 20 cycles of the strobe, at %0t", $time);
			other_errors++;
			exp_data_q.delete();
			exp_fault_q.delete();
			exp_lat_q.delete();
			start_q.delete();
			tag_q.delete();
		end
	endtask

	task automatic access(input logic store, input logic [2:0] op, input logic [31:0] base,
			input logic [31:0] offs, input logic [31:0] data);
		start_access(store, op, base, offs, data);
		wait_done();
	endtask

	initial begin
		logic [31:0] waddr;
		logic [31:0] off;
		lfsr = 16'd73;
		reset = 1'b1;
		ren = 1'b0;
		wen = 1'b0;
		funct3 = '0;
		src1 = '0;
		src2 = '0;
		imm = '0;
		model_data = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_fault(done, 1'b0, "done after reset");
		check_fault(fault, 1'b0, "fault after reset");
		check_fault(busy, 1'b0, "busy after reset");
		check_data(load_data, '0, "load_data after reset");

		// word round trips that split the address between src1 and imm
		repeat (8) begin
			waddr = rand_bits(8) << 2;
			off = rand_bits(4) << 2;
			access(1'b1, OP_SW, waddr - off, off, rand_bits(32));
			access(1'b0, OP_LW, waddr - off, off, '0);
		end

		// byte and halfword lanes
		repeat (3) begin
			waddr = rand_bits(8) << 2;
			access(1'b1, OP_SW, waddr, '0, rand_bits(32));
			for (int k = 0; k < 4; k++) begin
				access(1'b1, OP_SB, waddr, k, rand_bits(32));
				access(1'b0, OP_LB, waddr, k, '0);
				access(1'b0, OP_LBU, waddr, k, '0);
				access(1'b0, OP_LW, waddr, '0, '0);
				if (k % 2 == 0) begin
					access(1'b1, OP_SH, waddr, k, rand_bits(32));
					access(1'b0, OP_LH, waddr, k, '0);
					access(1'b0, OP_LHU, waddr, k, '0);
					access(1'b0, OP_LW, waddr, '0, '0);
				end
			end
		end

		// misaligned accesses and illegal codes
		waddr = rand_bits(8) << 2;
		access(1'b1, OP_SW, waddr, '0, rand_bits(32));
		access(1'b0, OP_LB, waddr, 32'd1, '0);
		for (int k = 1; k < 4; k++) begin
			access(1'b1, OP_SW, waddr, k, rand_bits(32));
			access(1'b0, OP_LW, waddr, k, '0);
			if (k != 2) begin
				access(1'b1, OP_SH, waddr, k, rand_bits(32));
				access(1'b0, OP_LH, waddr, k, '0);
			end
		end
		access(1'b0, 3'd3, waddr, '0, '0);
		access(1'b0, 3'd6, waddr, '0, '0);
		access(1'b0, 3'd7, waddr, '0, '0);
		access(1'b1, 3'd3, waddr, '0, rand_bits(32));
		access(1'b1, 3'd4, waddr, '0, rand_bits(32));
		access(1'b1, 3'd5, waddr, '0, rand_bits(32));
		access(1'b0, OP_LW, waddr, '0, '0);

		// out-of-range accesses include an address that would alias waddr if the index wrapped
		access(1'b1, OP_SW, 32'd4 * `LSU_MEM_WORDS, waddr, rand_bits(32));
		access(1'b0, OP_LW, 32'd4 * `LSU_MEM_WORDS, waddr, '0);
		access(1'b0, OP_LB, 32'hffff_ff00, 32'd3, '0);
		access(1'b1, OP_SB, 32'hffff_ff00, 32'd3, rand_bits(32));
		access(1'b0, OP_LW, waddr, '0, '0);

		// a strobe while busy is dropped
		access(1'b1, OP_SW, waddr, '0, rand_bits(32));
		start_access(1'b0, OP_LW, waddr, '0, '0);
		@(posedge clock);
		wen <= 1'b1;
		funct3 <= OP_SW;
		src1 <= waddr;
		src2 <= rand_bits(32);
		imm <= '0;
		@(posedge clock);
		wen <= 1'b0;
		wait_done();
		access(1'b0, OP_LW, waddr, '0, '0);

		repeat (4) @(negedge clock);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_top (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 ren,
	input  logic                 wen,
	input  logic [2:0]           funct3,
	input  logic [`LSU_XLEN-1:0] src1,
	input  logic [`LSU_XLEN-1:0] src2,
	input  logic [`LSU_XLEN-1:0] imm,
	output logic [`LSU_XLEN-1:0] load_data,
	output logic                 done,
	output logic                 fault,
	output logic                 busy
);
	import lsu_pkg::*;

	mem_req_s req;
	logic     misaligned;

	mem_bus_if bus_i ();

	lsu_ctrl ctrl_i (
		.clock      (clock),
		.reset      (reset),
		.ren        (ren),
		.wen        (wen),
		.funct3     (mem_op_e'(funct3)),
		.src1       (src1),
		.src2       (src2),
		.imm        (imm),
		.misaligned (misaligned),
		.req        (req),
		.bus        (bus_i),
		.done       (done),
		.fault      (fault),
		.busy       (busy)
	);

	store_align store_i (
		.req        (req),
		.bus        (bus_i),
		.misaligned (misaligned)
	);

	load_extend load_i (
		.clock     (clock),
		.reset     (reset),
		.req       (req),
		.bus       (bus_i),
		.load_data (load_data)
	);

	lsu_sram sram_i (
		.clock (clock),
		.reset (reset),
		.bus   (bus_i)
	);

endmodule

/* logic/lsu_sram.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_sram (
	input  logic clock,
	input  logic reset,
	mem_bus_if.slave bus
);
	import lsu_pkg::*;

	localparam int AW = $clog2(`LSU_MEM_WORDS);

	logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

	logic          rd_fire;
	logic          wr_fire;
	logic          ar_ok;
	logic          aw_ok;
	logic [AW-1:0] ar_idx;
	logic [AW-1:0] aw_idx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshakes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign bus.arready = bus.arvalid;
	assign bus.awready = bus.awvalid && bus.wvalid;    // address and data are taken together
	assign bus.wready = bus.awvalid && bus.wvalid;

	assign rd_fire = bus.arvalid && bus.arready;
	assign wr_fire = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

	assign ar_ok = (bus.araddr >> 2) < `LSU_MEM_WORDS;
	assign aw_ok = (bus.awaddr >> 2) < `LSU_MEM_WORDS;
	assign ar_idx = bus.araddr[AW+1:2];
	assign aw_idx = bus.awaddr[AW+1:2];

	// a response stays up until the master takes it
	always_ff @(posedge clock) begin
		if (reset) begin
			bus.rvalid <= 1'b0;
			bus.bvalid <= 1'b0;
		end else begin
			bus.rvalid <= rd_fire || (bus.rvalid && !bus.rready);
			bus.bvalid <= wr_fire || (bus.bvalid && !bus.bready);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			if (ar_ok) begin
				bus.rdata <= mem[ar_idx];
				bus.rresp <= RESP_OKAY;
			end else begin
				bus.rdata <= '0;
				bus.rresp <= RESP_SLVERR;
			end
		end
		if (wr_fire) begin
			bus.bresp <= aw_ok ? RESP_OKAY : RESP_SLVERR;
			if (aw_ok) begin
				for (int i = 0; i < `LSU_XLEN/8; i++) begin
					if (bus.wstrb[i])
						mem[aw_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) bus.wvalid |-> bus.wstrb != '0);

endmodule

/* logic/load_extend.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module load_extend (
	input  logic                 clock,
	input  logic                 reset,
	input  lsu_pkg::mem_req_s    req,
	mem_bus_if.monitor           bus,
	output logic [`LSU_XLEN-1:0] load_data
);
	import lsu_pkg::*;

	logic [`LSU_XLEN-1:0] shifted;
	logic [`LSU_XLEN-1:0] extended;

	assign shifted = bus.rdata >> {req.addr[1:0], 3'b000};    // addressed byte moves to lane 0

	always_comb begin
		case (req.op)
			OP_LB:   extended = {{24{shifted[7]}}, shifted[7:0]};
			OP_LH:   extended = {{16{shifted[15]}}, shifted[15:0]};
			OP_LBU:  extended = {24'h0, shifted[7:0]};
			OP_LHU:  extended = {16'h0, shifted[15:0]};
			default: extended = shifted;
		endcase
	end

	// an error response leaves the previous result in place
	always_ff @(posedge clock) begin
		if (reset)
			load_data <= '0;
		else if (bus.rvalid && bus.rresp == RESP_OKAY)
			load_data <= extended;
	end

	assert property (@(posedge clock) disable iff (reset) bus.rvalid |-> !req.is_store);

endmodule

/* logic/store_align.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module store_align (
	input  lsu_pkg::mem_req_s req,
	mem_bus_if.master         bus,
	output logic              misaligned
);
	import lsu_pkg::*;

	logic [`LSU_XLEN/8-1:0] strb_base;
	logic                   op_bad;
	logic                   half;
	logic                   word;

	assign bus.araddr = req.addr;
	assign bus.awaddr = req.addr;

	always_comb begin
		strb_base = '0;
		op_bad = 1'b0;
		if (req.is_store) begin
			case (req.op)
				OP_SB: strb_base = 4'b0001;
				OP_SH: strb_base = 4'b0011;
				OP_SW: strb_base = 4'b1111;
				default: op_bad = 1'b1;    // unsigned codes have no store form
			endcase
		end else begin
			op_bad = !(req.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});
		end
	end

	assign bus.wstrb = strb_base << req.addr[1:0];
	assign bus.wdata = req.sdata << {req.addr[1:0], 3'b000};

	// the low two bits of the code give the access size
	assign half = (req.op[1:0] == 2'b01);
	assign word = (req.op[1:0] == 2'b10);
	assign misaligned = op_bad || (half && req.addr[0]) || (word && |req.addr[1:0]);

endmodule

/* logic/lsu_ctrl.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_ctrl (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 ren,
	input  logic                 wen,
	input  lsu_pkg::mem_op_e     funct3,
	input  logic [`LSU_XLEN-1:0] src1,
	input  logic [`LSU_XLEN-1:0] src2,
	input  logic [`LSU_XLEN-1:0] imm,
	input  logic                 misaligned,
	output lsu_pkg::mem_req_s    req,
	mem_bus_if.master            bus,
	output logic                 done,
	output logic                 fault,
	output logic                 busy
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_RESP} state_e;

	state_e state;
	logic   issued;     // bus valids have been raised for this request
	logic   fault_q;
	logic   accept;
	logic   launch;
	logic   resp_err;

	assign accept = (state == ST_IDLE) && (ren || wen);
	assign launch = (state == ST_BUS) && !issued && !misaligned;
	assign resp_err = (bus.rvalid && bus.rresp != RESP_OKAY) ||
		(bus.bvalid && bus.bresp != RESP_OKAY);

	assign bus.rready = 1'b1;
	assign bus.bready = 1'b1;

	assign done = (state == ST_RESP);
	assign fault = done && fault_q;
	assign busy = (state != ST_IDLE);

	always_ff @(posedge clock) begin
		if (accept) begin
			req.op       <= funct3;
			req.is_store <= wen;
			req.addr     <= src1 + imm;
			req.sdata    <= src2;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= ST_IDLE;
			issued      <= 1'b0;
			fault_q     <= 1'b0;
			bus.arvalid <= 1'b0;
			bus.awvalid <= 1'b0;
			bus.wvalid  <= 1'b0;
		end else begin
			// each valid is held until its ready arrives
			bus.arvalid <= (bus.arvalid & ~bus.arready) | (launch & ~req.is_store);
			bus.awvalid <= (bus.awvalid & ~bus.awready) | (launch & req.is_store);
			bus.wvalid  <= (bus.wvalid & ~bus.wready) | (launch & req.is_store);
			case (state)
				ST_IDLE: begin
					if (accept)
						state <= ST_BUS;
				end
				ST_BUS: begin
					if (!issued) begin
						if (misaligned) begin
							state   <= ST_RESP;    // no bus transaction for a bad access
							fault_q <= 1'b1;
						end else begin
							issued <= 1'b1;
						end
					end else if (bus.rvalid || bus.bvalid) begin
						state   <= ST_RESP;
						fault_q <= resp_err;
					end
				end
				default: begin
					state  <= ST_IDLE;
					issued <= 1'b0;
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));
	assert property (@(posedge clock) disable iff (reset)
		bus.awvalid && !bus.awready |=> bus.awvalid && bus.wvalid && $stable(bus.wdata));
	assert property (@(posedge clock) disable iff (reset) !(ren && wen));

endmodule

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

interface mem_bus_if;
	import lsu_pkg::*;

	// read address and read data channels
	logic [`LSU_XLEN-1:0]   araddr;
	logic                   arvalid;
	logic                   arready;
	logic [`LSU_XLEN-1:0]   rdata;
	bus_resp_e              rresp;
	logic                   rvalid;
	logic                   rready;

	// write address, write data and write response channels
	logic [`LSU_XLEN-1:0]   awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [`LSU_XLEN-1:0]   wdata;
	logic [`LSU_XLEN/8-1:0] wstrb;
	logic                   wvalid;
	logic                   wready;
	bus_resp_e              bresp;
	logic                   bvalid;
	logic                   bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport slave (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport monitor (
		input rdata, rvalid, rresp
	);

endinterface

/* logic/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

	// encodings follow funct3 of the RV32 load and store instructions
	typedef enum logic [2:0] {
		OP_LB  = 3'b000,
		OP_LH  = 3'b001,
		OP_LW  = 3'b010,
		OP_LBU = 3'b100,
		OP_LHU = 3'b101
	} mem_op_e;

	// stores reuse the codes of the signed loads
	localparam mem_op_e OP_SB = OP_LB;
	localparam mem_op_e OP_SH = OP_LH;
	localparam mem_op_e OP_SW = OP_LW;

	typedef enum logic [1:0] {
		RESP_OKAY   = `LSU_RESP_OKAY,
		RESP_SLVERR = `LSU_RESP_SLVERR
	} bus_resp_e;

	typedef struct packed {
		mem_op_e              op;
		logic                 is_store;
		logic [`LSU_XLEN-1:0] addr;
		logic [`LSU_XLEN-1:0] sdata;    // store source before lane alignment
	} mem_req_s;

endpackage

/* include/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory and bus sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define LSU_MEM_WORDS 256           // addresses at or above four times this word count fault
`define LSU_XLEN 32                 // data and address width

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response codes in AXI encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define LSU_RESP_OKAY 2'b00
`define LSU_RESP_SLVERR 2'b10

`endif
